// ==== Makefile ====
# Verilator build and run of the slave_translator testbench

TOP := tb_slave_translator

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f slave_translator.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then \
		echo "simulation FAILED, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== common/bus_pkg.sv ====
/*
 * bus widths and the structs shared by the bridge and its testbench.
 * the system side is byte addressed, the peripheral side word addressed.
 * one data width on both sides, so no width adaptation happens.
 */

package bus_pkg;

   localparam int DATA_W      = 32;
   localparam int BYTE_ADDR_W = 16;
   localparam int BYTES_W     = DATA_W / 8;
   localparam int WORD_SHIFT  = 2;                       // log2 of BYTES_W
   localparam int WORD_ADDR_W = BYTE_ADDR_W - WORD_SHIFT;

   typedef enum logic [1:0] {
      op_none  = 2'd0,
      op_read  = 2'd1,
      op_write = 2'd2
   } bus_op_t;

   // ---------------------------------------------------------------------
   // system side
   // ---------------------------------------------------------------------
   typedef struct packed {
      bus_op_t                  op;
      logic [BYTE_ADDR_W-1:0]   address;
      logic [DATA_W-1:0]        writedata;
      logic [BYTES_W-1:0]       byteenable;
   } uav_req_t;

   typedef struct packed {
      logic                     readdatavalid;
      logic [DATA_W-1:0]        readdata;
   } uav_rsp_t;

   // decoded request, word addressed
   typedef struct packed {
      bus_op_t                  op;
      logic [WORD_ADDR_W-1:0]   address;
      logic [DATA_W-1:0]        writedata;
      logic [BYTES_W-1:0]       byteenable;
      logic [BYTES_W-1:0]       writebyteenable;
      logic                     begintransfer;
   } dec_req_t;

   // peripheral side command
   typedef struct packed {
      logic [WORD_ADDR_W-1:0]   address;
      logic [DATA_W-1:0]        writedata;
      logic [BYTES_W-1:0]       byteenable;
      logic [BYTES_W-1:0]       writebyteenable;
      logic                     read;
      logic                     write;
      logic                     begintransfer;
   } av_cmd_t;

endpackage

// ==== common/timing_pkg.sv ====
/*
 * wait-state timing for the peripheral side.
 * setup + read wait, and setup + write wait + hold, must each stay below
 * 2**COUNT_W. read latency of 0 is not supported.
 */

package timing_pkg;

   typedef enum logic [1:0] {
      ph_idle  = 2'd0,   // no transfer started
      ph_count = 2'd1,   // wait states running
      ph_done  = 2'd2    // accept cycle
   } timer_phase_t;

   localparam int COUNT_W = 4;

   // ---------------------------------------------------------------------
   // default peripheral timing
   // ---------------------------------------------------------------------
   localparam int DEF_SETUP_CYCLES      = 1;
   localparam int DEF_READ_WAIT_CYCLES  = 2;
   localparam int DEF_WRITE_WAIT_CYCLES = 1;
   localparam int DEF_HOLD_CYCLES       = 1;
   localparam int DEF_READ_LATENCY      = 2;   // at least 1

endpackage

// ==== slave_translator.f ====
common/bus_pkg.sv
common/timing_pkg.sv
verilog/request_decoder.sv
verilog/wait_timer.sv
verilog/read_return.sv
verilog/slave_translator.sv
verification/slave_translator_assert.sv
verification/tb_slave_translator.sv

// ==== verification/slave_translator_assert.sv ====
/*
 * protocol checks bound into every slave_translator instance.
 * READ_LATENCY is taken from the bound instance.
 * reset must be held at least READ_LATENCY cycles.
 */

`timescale 1ns/1ns

module slave_translator_assert #(
   parameter int READ_LATENCY = timing_pkg::DEF_READ_LATENCY
) (
   input logic               clk,
   input logic               reset,
   input logic               uav_waitrequest,
   input logic               read_accept,
   input bus_pkg::av_cmd_t   av_cmd,
   input bus_pkg::uav_rsp_t  uav_rsp
);

   // peripheral never sees both strobes
   read_write_exclusive: assert property (
      @(posedge clk) disable iff (reset) !(av_cmd.read && av_cmd.write)
   ) else $error("av_read and av_write are high in the same cycle");

   // ---------------------------------------------------------------------
   // first cycle after reset is always a wait cycle
   // ---------------------------------------------------------------------
   reset_holdoff: assert property (
      @(posedge clk) $fell(reset) |->
         (uav_waitrequest && !av_cmd.read && !av_cmd.write && !uav_rsp.readdatavalid)
   ) else $error("bridge not idle with waitrequest high after reset");

   // valid exactly READ_LATENCY cycles after each accepted read
   read_latency: assert property (
      @(posedge clk) disable iff (reset)
         uav_rsp.readdatavalid == $past(read_accept, READ_LATENCY)
   ) else $error("readdatavalid does not follow read_accept by READ_LATENCY cycles");

endmodule

bind slave_translator slave_translator_assert #(
   .READ_LATENCY (READ_LATENCY)
) u_slave_translator_assert (
   .clk             (clk),
   .reset           (reset),
   .uav_waitrequest (uav_waitrequest),
   .read_accept     (read_accept),
   .av_cmd          (av_cmd),
   .uav_rsp         (uav_rsp)
);

// ==== verification/tb_slave_translator.sv ====
/*
 * testbench for the bus bridge with a fixed-latency peripheral model.
 * the model memory holds 64 words, higher word addresses alias onto it.
 * stops at the first mismatch.
 */

`timescale 1ns/1ns

module tb_slave_translator;

   import bus_pkg::*;

   localparam int SETUP_CYCLES      = 1;
   localparam int READ_WAIT_CYCLES  = 1;
   localparam int WRITE_WAIT_CYCLES = 2;
   localparam int HOLD_CYCLES       = 1;
   localparam int READ_LATENCY      = 4;   // longer than a read so reads overlap

   localparam int CLK_NS       = 40;
   localparam int RESET_CYCLES = 8;
   localparam int DRIVE_NS     = 2;        // input skew after the rising edge
   localparam int ROWS         = 14;
   localparam int READ_N       = SETUP_CYCLES + READ_WAIT_CYCLES;
   localparam int WRITE_N      = SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES;
   localparam int MAX_N        = (READ_N > WRITE_N) ? READ_N : WRITE_N;
   localparam int WATCHDOG_NS  =
      ROWS * (MAX_N + READ_LATENCY + 4) * CLK_NS + RESET_CYCLES * CLK_NS;

   typedef struct packed {
      bus_op_t                 op;
      logic [BYTE_ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]       wdata;
      logic [BYTES_W-1:0]      be;
      logic                    rnd;        // random write data or read expected from ref_mem
      logic [DATA_W-1:0]       exp_data;
   } row_t;

   logic               clk;
   logic               reset;
   uav_req_t           uav_req;
   logic               uav_waitrequest;
   uav_rsp_t           uav_rsp;
   av_cmd_t            av_cmd;
   logic [DATA_W-1:0]  av_readdata;

   row_t               rows [ROWS];
   logic [DATA_W-1:0]  model_mem [64];
   logic [DATA_W-1:0]  ref_mem [64];
   logic [DATA_W-1:0]  rd_pipe [READ_LATENCY] = '{default: '0};
   int                 cycle_no = 0;
   int                 rsp_cycle_q [$];    // cycle in which each read returns
   logic [DATA_W-1:0]  rsp_data_q [$];

   slave_translator #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES),
      .READ_LATENCY      (READ_LATENCY)
   ) dut_i (
      .clk             (clk),
      .reset           (reset),
      .uav_req         (uav_req),
      .uav_waitrequest (uav_waitrequest),
      .uav_rsp         (uav_rsp),
      .av_cmd          (av_cmd),
      .av_readdata     (av_readdata)
   );

   initial clk = 1'b0;
   always #(CLK_NS / 2) clk = ~clk;

   always @(posedge clk) cycle_no <= cycle_no + 1;

   // ---------------------------------------------------------------------
   // peripheral model that never stalls
   // ---------------------------------------------------------------------
   always @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 64; i++) model_mem[i] <= fill_word(i);
      end else if (av_cmd.write) begin
         for (int b = 0; b < BYTES_W; b++) begin
            if (av_cmd.writebyteenable[b]) begin
               model_mem[av_cmd.address[5:0]][8*b +: 8] <= av_cmd.writedata[8*b +: 8];
            end
         end
      end
   end

   // data sampled in the accept cycle comes out READ_LATENCY edges later
   always @(posedge clk) begin
      rd_pipe[0] <= av_cmd.read ? model_mem[av_cmd.address[5:0]] : 32'hdead_beef;
      for (int s = 1; s < READ_LATENCY; s++) rd_pipe[s] <= rd_pipe[s-1];
   end

   assign av_readdata = rd_pipe[READ_LATENCY-1];

   function automatic logic [DATA_W-1:0] fill_word(input int idx);
      return {8'ha5, 8'(idx), 8'h5a, ~8'(idx)};
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [BYTES_W-1:0] be);
      logic [DATA_W-1:0] result;
      result = old_word;
      for (int b = 0; b < BYTES_W; b++) begin
         if (be[b]) result[8*b +: 8] = new_word[8*b +: 8];
      end
      return result;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("error: %s is 0x%h, expected 0x%h", name, got, exp);
         $display("Some tests failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // ---------------------------------------------------------------------
   // stimulus table
   // ---------------------------------------------------------------------
   task automatic load_table();
      for (int i = 0; i < 64; i++) ref_mem[i] = fill_word(i);
      rows[0]  = '{op_write, 16'h0010, 32'h1122_3344, 4'hf, 1'b0, 32'h0};
      rows[1]  = '{op_read,  16'h0010, 32'h0,         4'hf, 1'b0, 32'h1122_3344};
      rows[2]  = '{op_write, 16'h0010, 32'haabb_ccdd, 4'h5, 1'b0, 32'h0};  // partial
      rows[3]  = '{op_read,  16'h0010, 32'h0,         4'hf, 1'b0, 32'h11bb_33dd};
      rows[4]  = '{op_none,  16'h0000, 32'h0,         4'h0, 1'b0, 32'h0};
      rows[5]  = '{op_write, 16'h8034, 32'h0,         4'hf, 1'b1, 32'h0};
      rows[6]  = '{op_write, 16'h0020, 32'hcafe_f00d, 4'h8, 1'b0, 32'h0};
      rows[7]  = '{op_read,  16'h8034, 32'h0,         4'hf, 1'b1, 32'h0};  // back to back
      rows[8]  = '{op_read,  16'h0020, 32'h0,         4'hf, 1'b0, 32'hca08_5af7};
      rows[9]  = '{op_read,  16'h0010, 32'h0,         4'hf, 1'b0, 32'h11bb_33dd};
      rows[10] = '{op_none,  16'h0000, 32'h0,         4'h0, 1'b0, 32'h0};
      rows[11] = '{op_write, 16'h00fc, 32'h0bad_beef, 4'h3, 1'b0, 32'h0};
      rows[12] = '{op_read,  16'h00fc, 32'h0,         4'hf, 1'b0, 32'ha53f_beef};
      rows[13] = '{op_read,  16'h0040, 32'h0,         4'hf, 1'b0, 32'ha510_5aef};
   endtask

   // drives one row from posedge + DRIVE_NS until the accept cycle is over
   task automatic run_row(input row_t row);
      int                  cycles;
      int                  idx;
      logic                accepted;
      logic                exp_rd;
      logic                exp_wr;
      logic [DATA_W-1:0]   wdata;
      logic [BYTES_W-1:0]  exp_wbe;

      idx     = int'((row.addr >> WORD_SHIFT) & 16'h003f);
      wdata   = (row.op == op_write && row.rnd) ? $urandom : row.wdata;
      exp_wbe = (row.op == op_write) ? row.be : '0;
      uav_req.op         = row.op;
      uav_req.address    = row.addr;
      uav_req.writedata  = wdata;
      uav_req.byteenable = row.be;
      if (row.op == op_none) begin
         @(posedge clk);
         #DRIVE_NS;
      end else begin
         cycles   = 0;
         accepted = 1'b0;
         while (!accepted) begin
            @(negedge clk);
            cycles++;
            // strobe windows, counted from 0 in the first request cycle
            exp_rd = (row.op == op_read) && (cycles - 1 >= SETUP_CYCLES);
            exp_wr = (row.op == op_write) && (cycles - 1 >= SETUP_CYCLES)
                     && (cycles - 1 <= SETUP_CYCLES + WRITE_WAIT_CYCLES);
            check_value("av_begintransfer", 32'(av_cmd.begintransfer), 32'(cycles == 1));
            check_value("av_read", 32'(av_cmd.read), 32'(exp_rd));
            check_value("av_write", 32'(av_cmd.write), 32'(exp_wr));
            check_value("av_address", 32'(av_cmd.address), 32'(row.addr >> WORD_SHIFT));
            check_value("av_byteenable", 32'(av_cmd.byteenable), 32'(row.be));
            check_value("av_writebyteenable", 32'(av_cmd.writebyteenable), 32'(exp_wbe));
            check_value("av_writedata", av_cmd.writedata, wdata);
            if (!uav_waitrequest) begin
               accepted = 1'b1;
               if (row.op == op_read) begin
                  rsp_cycle_q.push_back(cycle_no + READ_LATENCY);
                  rsp_data_q.push_back(row.rnd ? ref_mem[idx] : row.exp_data);
               end
            end
            @(posedge clk);
            #DRIVE_NS;
         end
         check_value("request cycles", 32'(cycles),
                     32'(((row.op == op_read) ? READ_N : WRITE_N) + 1));
         if (row.op == op_write) ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, row.be);
      end
   endtask

   // read responses checked mid-cycle
   always @(negedge clk) begin
      if (!reset) begin
         if (rsp_cycle_q.size() != 0 && rsp_cycle_q[0] == cycle_no) begin
            check_value("readdatavalid", 32'(uav_rsp.readdatavalid), 32'd1);
            check_value("readdata", uav_rsp.readdata, rsp_data_q[0]);
            void'(rsp_cycle_q.pop_front());
            void'(rsp_data_q.pop_front());
         end else begin
            check_value("readdatavalid", 32'(uav_rsp.readdatavalid), 32'd0);
         end
      end
   end

   // ---------------------------------------------------------------------
   // main sequence and watchdog
   // ---------------------------------------------------------------------
   initial begin
      int held;

      void'($urandom(32'h6dc4_4ff8));
      reset   = 1'b1;
      uav_req = '0;
      load_table();
      // write without byte enables waiting through reset, memory stays as filled
      uav_req.op = op_write;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_NS;
      reset = 1'b0;
      @(negedge clk);                      // first cycle after reset
      check_value("uav_waitrequest", 32'(uav_waitrequest), 32'd1);
      check_value("av_read", 32'(av_cmd.read), 32'd0);
      check_value("av_write", 32'(av_cmd.write), 32'd0);
      held = 0;
      while (uav_waitrequest) begin
         @(negedge clk);
         held++;
      end
      check_value("request cycles after reset", 32'(held), 32'(WRITE_N + 1));
      @(posedge clk);
      #DRIVE_NS;
      for (int r = 0; r < ROWS; r++) run_row(rows[r]);
      uav_req = '0;
      while (rsp_cycle_q.size() != 0) @(posedge clk);
      repeat (2) @(posedge clk);
      $display("All tests passed");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the table did not finish within %0d ns", WATCHDOG_NS);
      $display("Some tests failed");
      $fatal(1, "watchdog expired");
   end

endmodule

// ==== verilog/read_return.sv ====
/*
 * read response path. the peripheral has a fixed latency, so valid is
 * rebuilt from the accept pulses; READ_LATENCY must be at least 1.
 * readdata is passed through and only meaningful with readdatavalid.
 */

`timescale 1ns/1ns

module read_return #(
   parameter int READ_LATENCY = timing_pkg::DEF_READ_LATENCY
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          read_accept,
   input  logic [bus_pkg::DATA_W-1:0]    av_readdata,
   output bus_pkg::uav_rsp_t             uav_rsp
);

   // one bit per cycle of latency, several reads may be in flight
   logic [READ_LATENCY-1:0] valid_sr;

   // ---------------------------------------------------------------------
   // latency pipeline
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid_sr <= '0;
      end else begin
         valid_sr[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            valid_sr[i] <= valid_sr[i-1];
         end
      end
   end

   // response
   always_comb begin
      uav_rsp.readdatavalid = valid_sr[READ_LATENCY-1];
      uav_rsp.readdata      = av_readdata;   // peripheral drives it in the valid cycle
   end

endmodule

// ==== verilog/request_decoder.sv ====
/*
 * address translation and byte-enable masking for one request.
 * addresses are assumed word aligned; low address bits are dropped,
 * not decoded from the byte enables.
 */

`timescale 1ns/1ns

module request_decoder (
   input  logic                 clk,
   input  logic                 reset,
   input  bus_pkg::uav_req_t    uav_req,
   input  logic                 waitrequest,
   output bus_pkg::dec_req_t    dec_req
);

   import bus_pkg::*;

   logic started;        // current request already had its first cycle
   logic is_write;
   logic begin_xfer;

   assign is_write   = (uav_req.op == op_write);
   assign begin_xfer = (uav_req.op != op_none) & ~started;

   // ---------------------------------------------------------------------
   // begin-transfer tracking
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         started <= 1'b0;
      end else if (!waitrequest) begin
         started <= 1'b0;               // accepted, next request starts fresh
      end else if (begin_xfer) begin
         started <= 1'b1;               // stalled first cycle
      end
   end

   // ---------------------------------------------------------------------
   // combinational decode
   // ---------------------------------------------------------------------
   always_comb begin
      dec_req.op              = uav_req.op;
      dec_req.address         = uav_req.address[BYTE_ADDR_W-1:WORD_SHIFT];
      dec_req.writedata       = uav_req.writedata;
      dec_req.byteenable      = uav_req.byteenable;
      dec_req.writebyteenable = uav_req.byteenable & {BYTES_W{is_write}};
      dec_req.begintransfer   = begin_xfer;
   end

endmodule

// ==== verilog/slave_translator.sv ====
/*
 * byte-addressed system bus to fixed-timing word peripheral bridge.
 * requester holds a request until uav_waitrequest is low.
 * the peripheral never stalls and returns read data READ_LATENCY
 * cycles after the read is accepted. no bursts, READ_LATENCY >= 1.
 */

`timescale 1ns/1ns

module slave_translator #(
   parameter int SETUP_CYCLES      = timing_pkg::DEF_SETUP_CYCLES,
   parameter int READ_WAIT_CYCLES  = timing_pkg::DEF_READ_WAIT_CYCLES,
   parameter int WRITE_WAIT_CYCLES = timing_pkg::DEF_WRITE_WAIT_CYCLES,
   parameter int HOLD_CYCLES       = timing_pkg::DEF_HOLD_CYCLES,
   parameter int READ_LATENCY      = timing_pkg::DEF_READ_LATENCY
) (
   input  logic                          clk,
   input  logic                          reset,
   input  bus_pkg::uav_req_t             uav_req,
   output logic                          uav_waitrequest,
   output bus_pkg::uav_rsp_t             uav_rsp,
   output bus_pkg::av_cmd_t              av_cmd,
   input  logic [bus_pkg::DATA_W-1:0]    av_readdata
);

   import bus_pkg::*;

   dec_req_t dec_req;
   logic     av_read;
   logic     av_write;
   logic     read_accept;

   // ---------------------------------------------------------------------
   // decode, execute, result
   // ---------------------------------------------------------------------
   request_decoder u_request_decoder (
      .clk         (clk),
      .reset       (reset),
      .uav_req     (uav_req),
      .waitrequest (uav_waitrequest),
      .dec_req     (dec_req)
   );

   wait_timer #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES)
   ) u_wait_timer (
      .clk         (clk),
      .reset       (reset),
      .op          (dec_req.op),
      .av_read     (av_read),
      .av_write    (av_write),
      .waitrequest (uav_waitrequest),
      .read_accept (read_accept)
   );

   read_return #(
      .READ_LATENCY (READ_LATENCY)
   ) u_read_return (
      .clk         (clk),
      .reset       (reset),
      .read_accept (read_accept),
      .av_readdata (av_readdata),
      .uav_rsp     (uav_rsp)
   );

   // peripheral command, strobes from the timer
   assign av_cmd.address         = dec_req.address;
   assign av_cmd.writedata       = dec_req.writedata;
   assign av_cmd.byteenable      = dec_req.byteenable;
   assign av_cmd.writebyteenable = dec_req.writebyteenable;
   assign av_cmd.read            = av_read;
   assign av_cmd.write           = av_write;
   assign av_cmd.begintransfer   = dec_req.begintransfer;

endmodule

// ==== verilog/wait_timer.sv ====
/*
 * wait-state generator for a peripheral without its own waitrequest.
 * a request is accepted at count N and so takes N+1 cycles.
 * the op must stay steady for the whole request.
 */

`timescale 1ns/1ns

module wait_timer #(
   parameter int SETUP_CYCLES      = timing_pkg::DEF_SETUP_CYCLES,
   parameter int READ_WAIT_CYCLES  = timing_pkg::DEF_READ_WAIT_CYCLES,
   parameter int WRITE_WAIT_CYCLES = timing_pkg::DEF_WRITE_WAIT_CYCLES,
   parameter int HOLD_CYCLES       = timing_pkg::DEF_HOLD_CYCLES
) (
   input  logic              clk,
   input  logic              reset,
   input  bus_pkg::bus_op_t  op,
   output logic              av_read,
   output logic              av_write,
   output logic              waitrequest,
   output logic              read_accept
);

   import bus_pkg::*;
   import timing_pkg::*;

   // count values, relative to the first request cycle
   localparam logic [COUNT_W-1:0] SETUP_END = COUNT_W'(SETUP_CYCLES);
   localparam logic [COUNT_W-1:0] READ_N    = COUNT_W'(SETUP_CYCLES + READ_WAIT_CYCLES);
   localparam logic [COUNT_W-1:0] WRITE_END = COUNT_W'(SETUP_CYCLES + WRITE_WAIT_CYCLES);
   localparam logic [COUNT_W-1:0] WRITE_N   =
      COUNT_W'(SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES);

   timer_phase_t        phase;
   logic [COUNT_W-1:0]  count;
   logic [COUNT_W-1:0]  next_count;
   logic [COUNT_W-1:0]  limit;
   logic                active;
   logic                reset_override;  // holds off the first cycle after reset

   assign active     = (op != op_none);
   assign limit      = (op == op_write) ? WRITE_N : READ_N;
   assign next_count = count + 1'b1;

   // ---------------------------------------------------------------------
   // phase machine and counter
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         phase          <= ph_idle;
         count          <= '0;
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
         case (phase)
            ph_idle: begin
               // zero-wait requests are accepted straight from idle
               if (active && !reset_override && limit != '0) begin
                  count <= next_count;
                  phase <= (next_count == limit) ? ph_done : ph_count;
               end
            end
            ph_count: begin
               if (!active) begin
                  count <= '0;                       // request dropped
                  phase <= ph_idle;
               end else begin
                  count <= next_count;
                  if (next_count == limit) begin
                     phase <= ph_done;
                  end
               end
            end
            default: begin                            // ph_done, accept cycle
               count <= '0;
               phase <= ph_idle;
            end
         endcase
      end
   end

   // ---------------------------------------------------------------------
   // strobes
   // ---------------------------------------------------------------------
   always_comb begin
      waitrequest = 1'b1;
      if (phase == ph_done && active) begin
         waitrequest = 1'b0;
      end else if (phase == ph_idle && active && limit == '0) begin
         waitrequest = 1'b0;
      end
      waitrequest = waitrequest | reset_override;
   end

   assign av_read  = (op == op_read) & ~reset_override & (count >= SETUP_END);
   assign av_write = (op == op_write) & ~reset_override
                   & (count >= SETUP_END) & (count <= WRITE_END);   // low during hold

   assign read_accept = ~waitrequest & (op == op_read);

endmodule
